// File: hw/ethSwitchPkg.sv
// Shared definitions for the four-port Ethernet switch
// Port indices, MAC address fields, stream widths and the rx FSM states
package ethSwitchPkg;

  localparam int NumPorts = 4;

  // Port roles, fixed by board wiring
  localparam int IdxEth1 = 0;
  localparam int IdxEth2 = 1;
  localparam int IdxPs   = 2;  // Processor side
  localparam int IdxRt   = 3;  // Real-time side

  typedef logic [7:0]  byteT;
  typedef logic [47:0] macT;

  localparam macT BroadcastMac = 48'hffff_ffff_ffff;

  // On-board MAC is vendor prefix, interface code, then 4'd0 and board id
  localparam logic [23:0] CompanyId = 24'hfa610e;
  localparam logic [15:0] PsMacCode = 16'h0300;
  localparam logic [15:0] RtMacCode = 16'h1394;

  localparam byteT SfdByte = 8'hd5;  // Ends the preamble

  // Preamble + start byte + dest MAC, so dest MAC is known when byte 0 leaves
  localparam int HeaderDelay    = 14;
  localparam int InterPacketGap = 12;  // Idle cycles after each packet

  typedef enum logic [1:0] {
    Idle,
    Header,
    Data
  } rxStateT;

endpackage

// File: hw/rxFrameParser.sv
// Receive side of one switch port
// Finds the start byte, captures dest and source MAC from the frame header,
// and delays the byte stream so the forward decision is ready before it leaves
module rxFrameParser (
  input  logic               RxClk,
  input  logic               rstN,
  input  logic               rxValid,
  input  ethSwitchPkg::byteT rxData,
  output ethSwitchPkg::macT  destMac,
  output ethSwitchPkg::macT  srcMac,
  output logic               headerDone,
  output logic               dlyValid,
  output logic               dlyFirst,
  output logic               dlyLast,
  output ethSwitchPkg::byteT dlyData
);
  localparam int Dly = ethSwitchPkg::HeaderDelay;

  ethSwitchPkg::rxStateT state;
  logic [3:0]            hdrCnt;      // Frame header byte 0..13
  logic [39:0]           hdrSr;       // Last five header bytes
  ethSwitchPkg::byteT    dataSr [Dly];
  logic [Dly:0]          vldSr;       // One stage longer, for the first-byte edge

  always_ff @(posedge RxClk or negedge rstN) begin
    if (!rstN) begin
      state      <= ethSwitchPkg::Idle;
      hdrCnt     <= '0;
      headerDone <= 1'b0;
    end else begin
      headerDone <= 1'b0;  // Single-cycle pulse
      case (state)
        ethSwitchPkg::Idle: begin
          // No check on the preamble itself
          if (rxValid && rxData == ethSwitchPkg::SfdByte) begin
            state  <= ethSwitchPkg::Header;
            hdrCnt <= '0;
          end
        end
        ethSwitchPkg::Header: begin
          if (!rxValid) begin
            state <= ethSwitchPkg::Idle;  // Runt, give up
          end else begin
            hdrCnt <= hdrCnt + 4'd1;
            if (hdrCnt == 4'd13) begin
              state      <= ethSwitchPkg::Data;
              headerDone <= 1'b1;
            end
          end
        end
        ethSwitchPkg::Data: if (!rxValid) state <= ethSwitchPkg::Idle;
        default: state <= ethSwitchPkg::Idle;
      endcase
    end
  end

  // MACs change in one step on their last byte, so the previous packet
  // still draining from the delay line keeps a stable dest address
  always_ff @(posedge RxClk) begin
    if (state == ethSwitchPkg::Header && rxValid) begin
      hdrSr <= {hdrSr[31:0], rxData};
      if (hdrCnt == 4'd5) destMac <= {hdrSr, rxData};
      if (hdrCnt == 4'd11) srcMac <= {hdrSr, rxData};
    end
  end

  // Delay line
  always_ff @(posedge RxClk) begin
    dataSr[0] <= rxData;
    for (int k = 1; k < Dly; k++) begin
      dataSr[k] <= dataSr[k-1];
    end
  end

  always_ff @(posedge RxClk or negedge rstN) begin
    if (!rstN) vldSr <= '0;
    else       vldSr <= {vldSr[Dly-1:0], rxValid};
  end

  assign dlyData  = dataSr[Dly-1];
  assign dlyValid = vldSr[Dly-1];
  assign dlyFirst = vldSr[Dly-1] & ~vldSr[Dly];    // Rising edge of delayed valid
  assign dlyLast  = vldSr[Dly-1] & ~vldSr[Dly-2];  // Next one is not valid

  // Every burst reaches the data phase before it ends, no runt headers
  assert property (@(posedge RxClk) disable iff (!rstN)
    $fell(rxValid) |-> $past(state) == ethSwitchPkg::Data);

endmodule

// File: hw/forwardDecide.sv
// Forwarding decision for all four in-ports
// Learns the host MAC seen on Eth1 and Eth2, builds the primary MAC of each
// port and gives one out-port mask per in-port
module forwardDecide (
  input  logic              RxClk,
  input  logic              rstN,
  input  logic [3:0]        boardId,
  input  logic [3:0]        portActive,
  input  ethSwitchPkg::macT destMac [ethSwitchPkg::NumPorts],
  input  ethSwitchPkg::macT srcMac [ethSwitchPkg::NumPorts],
  input  logic [3:0]        headerDone,
  output logic [3:0]        fwdMask [ethSwitchPkg::NumPorts]  // [in][out]
);
  ethSwitchPkg::macT hostMac [ethSwitchPkg::IdxEth1:ethSwitchPkg::IdxEth2];
  ethSwitchPkg::macT primaryMac [ethSwitchPkg::NumPorts];  // Per out-port
  logic [3:0]        match [ethSwitchPkg::NumPorts];       // Dest hits another port
  logic [3:0]        isBcast;
  logic [3:0]        noMatch;                              // Unknown dest, flood hosts

  // Host learning, forgotten when the link drops
  always_ff @(posedge RxClk or negedge rstN) begin
    if (!rstN) begin
      for (int p = ethSwitchPkg::IdxEth1; p <= ethSwitchPkg::IdxEth2; p++) begin
        hostMac[p] <= ethSwitchPkg::BroadcastMac;
      end
    end else begin
      for (int p = ethSwitchPkg::IdxEth1; p <= ethSwitchPkg::IdxEth2; p++) begin
        if (!portActive[p])     hostMac[p] <= ethSwitchPkg::BroadcastMac;
        else if (headerDone[p]) hostMac[p] <= srcMac[p];
      end
    end
  end

  always_comb begin
    primaryMac[ethSwitchPkg::IdxEth1] = hostMac[ethSwitchPkg::IdxEth1];
    primaryMac[ethSwitchPkg::IdxEth2] = hostMac[ethSwitchPkg::IdxEth2];
    primaryMac[ethSwitchPkg::IdxPs] =
      {ethSwitchPkg::CompanyId, ethSwitchPkg::PsMacCode, 4'd0, boardId};
    primaryMac[ethSwitchPkg::IdxRt] =
      {ethSwitchPkg::CompanyId, ethSwitchPkg::RtMacCode, 4'd0, boardId};
  end

  always_comb begin
    for (int i = 0; i < ethSwitchPkg::NumPorts; i++) begin
      for (int o = 0; o < ethSwitchPkg::NumPorts; o++) begin
        match[i][o] = (o != i) && (destMac[i] == primaryMac[o]);  // Own port never counts
      end
      isBcast[i] = (destMac[i] == ethSwitchPkg::BroadcastMac);
      noMatch[i] = ~|match[i];
    end
  end

  always_comb begin
    for (int i = 0; i < ethSwitchPkg::NumPorts; i++) begin
      for (int o = 0; o < ethSwitchPkg::NumPorts; o++) begin
        fwdMask[i][o] = (o != i) && portActive[o] &&
                        (isBcast[i] || match[i][o] ||
                         ((o == ethSwitchPkg::IdxEth1 || o == ethSwitchPkg::IdxEth2) &&
                          noMatch[i]));
      end
    end
  end

endmodule

// File: hw/packetQueue.sv
// Store-and-forward byte queue for one in-port to out-port pair
// Each entry keeps a last-byte flag. A packet is accepted or dropped whole,
// decided on its first byte from the free space left
module packetQueue #(
  parameter int QueueDepth    = 128,
  parameter int MaxFrameBytes = 64
) (
  input  logic               RxClk,
  input  logic               rstN,
  input  logic               flush,    // Out-port link down
  input  logic               wrEn,
  input  logic               wrFirst,
  input  logic               wrLast,
  input  ethSwitchPkg::byteT wrData,
  input  logic               popEn,
  output logic               pktAvail,
  output logic               headLast,
  output ethSwitchPkg::byteT headData
);
  localparam int AddrW = $clog2(QueueDepth);
  localparam int CntW  = AddrW + 1;

  logic [8:0]       mem [QueueDepth];  // {last, data}
  logic [AddrW-1:0] wrPtr;
  logic [AddrW-1:0] rdPtr;
  logic [CntW-1:0]  used;              // Bytes stored
  logic [CntW-1:0]  pktCnt;            // Complete packets stored
  logic             accept;            // Decision for the packet in flight
  logic             fits;
  logic             doWrite;
  logic             popLast;

  assign fits    = (QueueDepth - int'(used)) >= MaxFrameBytes;
  assign doWrite = wrEn && !flush && (wrFirst ? fits : accept);
  assign popLast = popEn && headLast;

  always_ff @(posedge RxClk) begin
    if (doWrite) mem[wrPtr] <= {wrLast, wrData};
  end

  always_ff @(posedge RxClk or negedge rstN) begin
    if (!rstN) begin
      wrPtr  <= '0;
      rdPtr  <= '0;
      used   <= '0;
      pktCnt <= '0;
      accept <= 1'b0;
    end else if (flush) begin
      wrPtr  <= '0;
      rdPtr  <= '0;
      used   <= '0;
      pktCnt <= '0;
      accept <= 1'b0;
    end else begin
      // Relatch on every first byte, a mask rising mid-packet writes nothing
      if (wrFirst) accept <= wrEn && fits;
      if (doWrite) wrPtr <= (wrPtr == AddrW'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
      if (popEn)   rdPtr <= (rdPtr == AddrW'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
      used   <= used + CntW'(doWrite) - CntW'(popEn);
      pktCnt <= pktCnt + CntW'(doWrite && wrLast) - CntW'(popLast);  // Whole packets only
    end
  end

  assign pktAvail = (pktCnt != '0);
  assign headData = mem[rdPtr][7:0];  // Head byte, read asynchronously
  assign headLast = mem[rdPtr][8];

  // Scheduler pops only queues that hold a complete packet
  assert property (@(posedge RxClk) disable iff (!rstN) popEn |-> pktAvail);

endmodule

// File: hw/txScheduler.sv
// Transmit scheduler of one out-port
// Round-robin grant over the input queues, one packet at a time, with the
// ready input as back-pressure and an interpacket gap after every packet
module txScheduler (
  input  logic               RxClk,
  input  logic               rstN,
  input  logic               portReady,
  input  logic [3:0]         pktAvail,
  input  logic [3:0]         headLast,
  input  ethSwitchPkg::byteT headData [ethSwitchPkg::NumPorts],
  output logic [3:0]         popEn,
  output logic               txEn,
  output ethSwitchPkg::byteT txData
);
  logic [1:0] curIdx;   // Input being served, or last one served
  logic [1:0] cand;
  logic [1:0] nextIdx;
  logic       found;
  logic       granted;
  logic       sending;
  logic [3:0] gapCnt;

  // Queue may be flushed under a grant, so also qualify with pktAvail
  assign sending = granted && portReady && pktAvail[curIdx];
  assign txEn    = sending;
  assign txData  = headData[curIdx];

  always_comb begin
    popEn         = '0;
    popEn[curIdx] = sending;
  end

  // Nearest input after curIdx wins, curIdx itself comes last
  always_comb begin
    found   = 1'b0;
    nextIdx = curIdx;
    cand    = curIdx;
    for (int k = ethSwitchPkg::NumPorts; k >= 1; k--) begin
      cand = curIdx + 2'(k);
      if (pktAvail[cand]) begin
        found   = 1'b1;
        nextIdx = cand;
      end
    end
  end

  always_ff @(posedge RxClk or negedge rstN) begin
    if (!rstN) begin
      curIdx  <= 2'd3;  // First search starts at input 0
      granted <= 1'b0;
      gapCnt  <= '0;
    end else if (granted) begin
      if (!pktAvail[curIdx]) begin
        granted <= 1'b0;  // Flushed, nothing left to send
      end else if (portReady && headLast[curIdx]) begin
        granted <= 1'b0;
        gapCnt  <= 4'(ethSwitchPkg::InterPacketGap);
      end
    end else if (gapCnt != '0) begin
      gapCnt <= gapCnt - 4'd1;
    end else if (found) begin
      curIdx  <= nextIdx;
      granted <= 1'b1;
    end
  end

  assert property (@(posedge RxClk) disable iff (!rstN) $onehot0(popEn));

endmodule

// File: hw/ethSwitch.sv
// Four-port Ethernet switch, single clock
// Per in-port parser, shared forward decision, one queue per in/out pair
// and a round-robin transmit scheduler per out-port
module ethSwitch #(
  parameter int QueueDepth    = 128,  // Bytes per queue
  parameter int MaxFrameBytes = 64
) (
  input  logic               RxClk,
  input  logic               rstN,
  input  logic [3:0]         boardId,
  input  logic [3:0]         portActive,  // Link up, bit per port
  input  logic [3:0]         portReady,
  input  logic [3:0]         rxValid,
  input  ethSwitchPkg::byteT rxData [ethSwitchPkg::NumPorts],
  output logic [3:0]         txEn,
  output ethSwitchPkg::byteT txData [ethSwitchPkg::NumPorts]
);
  ethSwitchPkg::macT  destMac [ethSwitchPkg::NumPorts];
  ethSwitchPkg::macT  srcMac [ethSwitchPkg::NumPorts];
  logic [3:0]         headerDone;
  logic [3:0]         dlyValid;
  logic [3:0]         dlyFirst;
  logic [3:0]         dlyLast;
  ethSwitchPkg::byteT dlyData [ethSwitchPkg::NumPorts];
  logic [3:0]         fwdMask [ethSwitchPkg::NumPorts];  // [in][out]

  // Queue side, all indexed [out][in]
  logic [3:0]         qAvail [ethSwitchPkg::NumPorts];
  logic [3:0]         qLast [ethSwitchPkg::NumPorts];
  logic [3:0]         qPop [ethSwitchPkg::NumPorts];
  ethSwitchPkg::byteT qData [ethSwitchPkg::NumPorts][ethSwitchPkg::NumPorts];

  for (genvar i = 0; i < ethSwitchPkg::NumPorts; i++) begin : gRx
    rxFrameParser uRx (
      .RxClk, .rstN,
      .rxValid(rxValid[i]), .rxData(rxData[i]),
      .destMac(destMac[i]), .srcMac(srcMac[i]), .headerDone(headerDone[i]),
      .dlyValid(dlyValid[i]), .dlyFirst(dlyFirst[i]), .dlyLast(dlyLast[i]),
      .dlyData(dlyData[i])
    );
  end

  forwardDecide uFwd (
    .RxClk, .rstN, .boardId, .portActive,
    .destMac, .srcMac, .headerDone, .fwdMask
  );

  for (genvar o = 0; o < ethSwitchPkg::NumPorts; o++) begin : gOut
    for (genvar i = 0; i < ethSwitchPkg::NumPorts; i++) begin : gIn
      if (i == o) begin : gDiag
        // No loopback queue
        assign qAvail[o][i] = 1'b0;
        assign qLast[o][i]  = 1'b0;
        assign qData[o][i]  = '0;
      end else begin : gQueue
        packetQueue #(
          .QueueDepth(QueueDepth), .MaxFrameBytes(MaxFrameBytes)
        ) uQueue (
          .RxClk, .rstN,
          .flush(!portActive[o]),
          .wrEn(dlyValid[i] & fwdMask[i][o]),
          .wrFirst(dlyFirst[i]), .wrLast(dlyLast[i]), .wrData(dlyData[i]),
          .popEn(qPop[o][i]),
          .pktAvail(qAvail[o][i]), .headLast(qLast[o][i]), .headData(qData[o][i])
        );
      end
    end

    txScheduler uTx (
      .RxClk, .rstN, .portReady(portReady[o]),
      .pktAvail(qAvail[o]), .headLast(qLast[o]), .headData(qData[o]),
      .popEn(qPop[o]), .txEn(txEn[o]), .txData(txData[o])
    );
  end

endmodule

// File: bench/ethSwitchChecker.sv
// Output checker for the Ethernet switch testbench
// Rebuilds packets per out-port from txEn and txData, picks the expected
// list from the in-port tag and compares every byte in order
module ethSwitchChecker (
  input logic               RxClk,
  input logic               rstN,
  input logic [3:0]         txEn,
  input ethSwitchPkg::byteT txData [ethSwitchPkg::NumPorts]
);
  localparam int TagPos = 22;  // Frame byte 14 after the start byte

  ethSwitchPkg::byteT expBytes [ethSwitchPkg::NumPorts][ethSwitchPkg::NumPorts][$];  // [in][out]
  int                 expLen [ethSwitchPkg::NumPorts][ethSwitchPkg::NumPorts][$];
  ethSwitchPkg::byteT got [ethSwitchPkg::NumPorts][$];  // Packet building on each out-port
  int                 pending;      // Expected copies not yet seen
  int                 errors;
  int                 missing;
  int                 checkedPkts;

  initial begin
    pending     = 0;
    errors      = 0;
    missing     = 0;
    checkedPkts = 0;
  end

  task automatic expectByte(input int inP, input int outP, input ethSwitchPkg::byteT b);
    expBytes[inP][outP].push_back(b);
  endtask

  task automatic expectEnd(input int inP, input int outP, input int len);
    expLen[inP][outP].push_back(len);
    pending++;
  endtask

  task automatic comparePacket(input int o, input int tag);
    ethSwitchPkg::byteT want;
    for (int k = 0; k < got[o].size(); k++) begin
      want = expBytes[tag][o].pop_front();
      if (got[o][k] !== want) begin
        errors++;
        $display("[ERROR] %0t txData[%0d] byte %0d from port %0d: got %02h, expected %02h",
                 $time, o, k, tag, got[o][k], want);
      end
    end
    void'(expLen[tag][o].pop_front());
    got[o].delete();
    pending--;
    checkedPkts++;
  endtask

  always @(posedge RxClk) begin
    int tag;
    if (rstN) begin
      for (int o = 0; o < ethSwitchPkg::NumPorts; o++) begin
        if (txEn[o]) begin
          got[o].push_back(txData[o]);
          if (got[o].size() > TagPos) begin
            tag = int'(got[o][TagPos]);
            if (tag >= ethSwitchPkg::NumPorts || tag == o || expLen[tag][o].size() == 0) begin
              errors++;
              $display("Unexpected packet on out-port %0d with in-port tag %0d at %0t",
                       o, tag, $time);
              got[o].delete();  // Resync on the next packet
            end else if (got[o].size() == expLen[tag][o][0]) begin
              comparePacket(o, tag);
            end
          end
        end
      end
    end
  end

  task automatic reportMissing();
    for (int i = 0; i < ethSwitchPkg::NumPorts; i++) begin
      for (int o = 0; o < ethSwitchPkg::NumPorts; o++) begin
        if (expLen[i][o].size() != 0) begin
          missing += expLen[i][o].size();
          $display("Port %0d to port %0d never delivered %0d packets",
                   i, o, expLen[i][o].size());
        end
      end
    end
    for (int o = 0; o < ethSwitchPkg::NumPorts; o++) begin
      if (got[o].size() != 0) begin
        errors++;
        $display("Out-port %0d stopped in the middle of a packet", o);
      end
    end
  endtask

endmodule

// File: bench/ethSwitchTb.sv
// Testbench for the four-port Ethernet switch
// Sends framed packets built from an LFSR, predicts forwarding, learning and
// queue drops, and hands each expected copy to the output checker
module ethSwitchTb;
  localparam int QueueDepth    = 128;
  localparam int MaxFrameBytes = 64;
  localparam int NumRandom     = 24;  // Sent in pairs
  localparam int NumPackets    = 41;  // All phases together
  localparam int NumStall      = 5;

  logic               RxClk;
  logic               rstN;
  logic [3:0]         boardId;
  logic [3:0]         portActive;
  logic [3:0]         portReady;
  logic [3:0]         rxValid;
  ethSwitchPkg::byteT rxData [ethSwitchPkg::NumPorts];
  logic [3:0]         txEn;
  ethSwitchPkg::byteT txData [ethSwitchPkg::NumPorts];

  logic [31:0]        lfsr;
  logic               randReady;  // Toggle portReady every cycle
  logic [7:0]         seqNum;
  ethSwitchPkg::macT  hostModel [ethSwitchPkg::NumPorts];  // Eth1 and Eth2 entries used
  int                 fill [ethSwitchPkg::NumPorts][ethSwitchPkg::NumPorts];  // [in][out]
  ethSwitchPkg::byteT pkt [64];

  ethSwitch #(.QueueDepth(QueueDepth), .MaxFrameBytes(MaxFrameBytes)) u_ethSwitch (
    .RxClk, .rstN, .boardId, .portActive, .portReady,
    .rxValid, .rxData, .txEn, .txData
  );

  ethSwitchChecker uChecker (.RxClk, .rstN, .txEn, .txData);

  always #10 RxClk = ~RxClk;

  // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic int randLen();
    return 24 + int'(takeBits(6) % 37);  // 24..60 bytes incl. preamble
  endfunction

  function automatic ethSwitchPkg::macT srcFor(input int p);
    return 48'h0200_0000_0010 + 48'(p);
  endfunction

  function automatic ethSwitchPkg::macT primaryOf(input int p);
    case (p)
      ethSwitchPkg::IdxPs:
        return {ethSwitchPkg::CompanyId, ethSwitchPkg::PsMacCode, 4'd0, boardId};
      ethSwitchPkg::IdxRt:
        return {ethSwitchPkg::CompanyId, ethSwitchPkg::RtMacCode, 4'd0, boardId};
      default: return hostModel[p];  // Learned host
    endcase
  endfunction

  // Reference forwarding rule, one bit per out-port
  function automatic logic [3:0] refMask(input int inP, input ethSwitchPkg::macT dst);
    logic [3:0] mask;
    logic       known;  // Dest names some port other than the in-port
    known = 1'b0;
    for (int p = 0; p < ethSwitchPkg::NumPorts; p++) begin
      if (p != inP && dst == primaryOf(p)) known = 1'b1;
    end
    for (int o = 0; o < ethSwitchPkg::NumPorts; o++) begin
      mask[o] = (o != inP) && portActive[o] &&
                (dst == ethSwitchPkg::BroadcastMac || dst == primaryOf(o) ||
                 ((o == ethSwitchPkg::IdxEth1 || o == ethSwitchPkg::IdxEth2) && !known));
    end
    return mask;
  endfunction

  task automatic tick();
    @(negedge RxClk);
    if (randReady) portReady = 4'(takeBits(4));
  endtask

  task automatic sendPacket(input int inP, input ethSwitchPkg::macT dst, input int len);
    ethSwitchPkg::macT src;
    logic [3:0]        mask;
    src = srcFor(inP);
    for (int k = 0; k < 7; k++) pkt[k] = 8'h55;  // Preamble
    pkt[7] = ethSwitchPkg::SfdByte;
    for (int k = 0; k < 6; k++) begin
      pkt[8 + k]  = dst[47 - 8 * k -: 8];  // MSB first
      pkt[14 + k] = src[47 - 8 * k -: 8];
    end
    pkt[20] = 8'h08;
    pkt[21] = 8'h00;
    pkt[22] = 8'(inP);  // Port tag
    pkt[23] = seqNum;
    for (int k = 24; k < len; k++) pkt[k] = 8'(takeBits(8));
    seqNum++;
    // Learning lands mid-packet, never affects the own copy
    if ((inP == ethSwitchPkg::IdxEth1 || inP == ethSwitchPkg::IdxEth2) && portActive[inP])
      hostModel[inP] = src;
    mask = refMask(inP, dst);
    for (int o = 0; o < ethSwitchPkg::NumPorts; o++) begin
      if (mask[o] && QueueDepth - fill[inP][o] >= MaxFrameBytes) begin
        fill[inP][o] += len;  // No pops assumed until the next drain
        for (int k = 0; k < len; k++) uChecker.expectByte(inP, o, pkt[k]);
        uChecker.expectEnd(inP, o, len);
      end
    end
    for (int k = 0; k < len; k++) begin
      tick();
      rxValid[inP] = 1'b1;
      rxData[inP]  = pkt[k];
    end
    tick();
    rxValid[inP] = 1'b0;
    rxData[inP]  = '0;
    repeat (ethSwitchPkg::HeaderDelay + 4) tick();  // Let the delay line empty
  endtask

  // Wait for every expected copy, then all queues are empty
  task automatic drain();
    while (uChecker.pending != 0) tick();
    repeat (ethSwitchPkg::InterPacketGap + 2) tick();
    for (int i = 0; i < ethSwitchPkg::NumPorts; i++) begin
      for (int o = 0; o < ethSwitchPkg::NumPorts; o++) fill[i][o] = 0;
    end
  endtask

  task automatic setActive(input int p, input logic v);
    tick();
    portActive[p] = v;
    if (!v) hostModel[p] = ethSwitchPkg::BroadcastMac;  // Link down forgets the host
    repeat (4) tick();
  endtask

  initial begin
    repeat (NumPackets * (60 + ethSwitchPkg::InterPacketGap) * 4) @(posedge RxClk);
    $display("Timeout, packets still outstanding after the time limit");
    $display("sim failed");
    $finish;
  end

  initial begin
    RxClk      = 1'b0;
    rstN       = 1'b0;
    lfsr       = 32'h1ff8;
    randReady  = 1'b0;
    seqNum     = '0;
    portActive = 4'hf;
    portReady  = 4'hf;
    rxValid    = '0;
    for (int p = 0; p < ethSwitchPkg::NumPorts; p++) begin
      rxData[p]    = '0;
      hostModel[p] = ethSwitchPkg::BroadcastMac;
      for (int o = 0; o < ethSwitchPkg::NumPorts; o++) fill[p][o] = 0;
    end
    boardId = 4'(takeBits(4));
    repeat (5) @(negedge RxClk);
    rstN = 1'b1;
    repeat (2) tick();

    // Broadcast from each in-port
    for (int p = 0; p < ethSwitchPkg::NumPorts; p++) begin
      sendPacket(p, ethSwitchPkg::BroadcastMac, randLen());
      drain();
    end
    // On-board addresses, then unknown addresses
    sendPacket(ethSwitchPkg::IdxEth1, primaryOf(ethSwitchPkg::IdxPs), randLen());
    drain();
    sendPacket(ethSwitchPkg::IdxEth2, primaryOf(ethSwitchPkg::IdxRt), randLen());
    drain();
    sendPacket(ethSwitchPkg::IdxPs, 48'h0a00_1234_5678, randLen());
    drain();
    sendPacket(ethSwitchPkg::IdxEth1, 48'h0a00_8765_4321, randLen());
    drain();

    // Learned host on Eth1, then forgotten on link down
    sendPacket(ethSwitchPkg::IdxEth1, 48'h0a00_0000_0001, randLen());
    drain();
    sendPacket(ethSwitchPkg::IdxPs, srcFor(ethSwitchPkg::IdxEth1), randLen());
    drain();
    setActive(ethSwitchPkg::IdxEth1, 1'b0);
    setActive(ethSwitchPkg::IdxEth1, 1'b1);
    sendPacket(ethSwitchPkg::IdxPs, srcFor(ethSwitchPkg::IdxEth1), randLen());
    drain();

    // Random traffic under random back-pressure
    randReady = 1'b1;
    for (int g = 0; g < NumRandom / 2; g++) begin
      for (int n = 0; n < 2; n++) begin
        int                inP;
        int                cls;
        ethSwitchPkg::macT dst;
        inP = int'(takeBits(2));
        cls = int'(takeBits(3));
        case (cls)
          0, 1: dst = ethSwitchPkg::BroadcastMac;
          2: dst = primaryOf(ethSwitchPkg::IdxPs);
          3: dst = primaryOf(ethSwitchPkg::IdxRt);
          4: dst = srcFor(ethSwitchPkg::IdxEth1);
          5: dst = srcFor(ethSwitchPkg::IdxEth2);
          default: dst = {16'h0a00, takeBits(32)};
        endcase
        sendPacket(inP, dst, randLen());
      end
      drain();
    end
    randReady = 1'b0;
    portReady = 4'hf;

    // RT stalled, the queue fills and later packets drop whole
    tick();
    portReady[ethSwitchPkg::IdxRt] = 1'b0;
    for (int n = 0; n < NumStall; n++) begin
      sendPacket(ethSwitchPkg::IdxEth1, primaryOf(ethSwitchPkg::IdxRt), randLen());
    end
    tick();
    portReady[ethSwitchPkg::IdxRt] = 1'b1;
    drain();

    // Inactive out-port gets nothing
    setActive(ethSwitchPkg::IdxEth2, 1'b0);
    sendPacket(ethSwitchPkg::IdxPs, ethSwitchPkg::BroadcastMac, randLen());
    drain();
    setActive(ethSwitchPkg::IdxEth2, 1'b1);

    uChecker.reportMissing();
    $display("Packets checked %0d, errors %0d, missing %0d",
             uChecker.checkedPkts, uChecker.errors, uChecker.missing);
    if (uChecker.errors == 0 && uChecker.missing == 0 && uChecker.checkedPkts > 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// File: vlog.f
hw/ethSwitchPkg.sv
hw/rxFrameParser.sv
hw/forwardDecide.sv
hw/packetQueue.sv
hw/txScheduler.sv
hw/ethSwitch.sv
bench/ethSwitchChecker.sv
bench/ethSwitchTb.sv

// File: Makefile
# Verilator build and run of the Ethernet switch testbench
VERILATOR ?= verilator
TOP       ?= ethSwitchTb
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIMBIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIMBIN)
	./$(SIMBIN) | tee $(LOG)
	grep -qx 'sim passed' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
